// File: sources.f
+incdir+hdl
hdl/sparse_cnn_pkg.sv
hdl/sparse_chunk_buf.sv
hdl/sparse_match_engine.sv
hdl/compute_unit.sv
hdl/compute_cluster.sv
verif/compute_cluster_chk.sv
verif/tb_compute_cluster.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench, the exit status carries the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_compute_cluster -o tb_compute_cluster \
	&& ./obj_dir/tb_compute_cluster \
	|| exit 1

// File: verif/tb_compute_cluster.sv
`timescale 1ns/10ps
`include "sparse_cnn_params.svh"

module tb_compute_cluster import sparse_cnn_pkg::*; ();

	localparam int CLK_PERIOD = 8;
	localparam int BUS = `BUS_SIZE;
	localparam int SEG_NUM = `WR_DAT_CYC_NUM;
	localparam int CHUNK = `CHUNK_SIZE;
	localparam int CU_NUM = `COMPUTE_UNIT_NUM;
	localparam int OUT_NUM = `OUTPUT_BUF_NUM;
	localparam int SEG_W = `SEG_IDX_W;
	localparam int CU_W = `CU_IDX_W;
	localparam int ACC_SEL_W = `ACC_SEL_W;
	// 40 cycles per chunk run, plus room for reset, writes and checks
	localparam int NUM_RUNS = 12;
	localparam int TIMEOUT_CYCLES = 40 * NUM_RUNS + 500;

	logic clk;
	logic rst;
	chunk_beat_t ifm_beat;
	logic ifm_wr_valid;
	logic [SEG_W-1:0] ifm_wr_count;
	logic ifm_wr_sel;
	logic ifm_rd_sel;
	chunk_beat_t fil_beat;
	logic fil_wr_valid;
	logic [SEG_W-1:0] fil_wr_count;
	logic fil_wr_sel;
	logic fil_rd_sel;
	logic [CU_NUM-1:0] fil_cu_mask;
	logic run_valid;
	logic chunk_start;
	logic [SEG_W-1:0] seg_last;
	logic [ACC_SEL_W-1:0] acc_sel;
	logic chunk_end;
	logic [CU_W-1:0] out_sel;
	out_buf_t out_buf;

	int seed;
	int cycle_cnt = 0;

	// Dense reference data with one IFM shared by all units
	logic signed [7:0] ifm_mem [2][CHUNK];
	logic signed [7:0] fil_mem [CU_NUM][2][CHUNK];
	int exp_acc [CU_NUM][OUT_NUM];

	compute_cluster dut0 (
		 .clk_i(clk)
		,.rst_i(rst)
		,.ifm_beat_i(ifm_beat)
		,.ifm_chunk_wr_valid_i(ifm_wr_valid)
		,.ifm_chunk_wr_count_i(ifm_wr_count)
		,.ifm_chunk_wr_sel_i(ifm_wr_sel)
		,.ifm_chunk_rd_sel_i(ifm_rd_sel)
		,.fil_beat_i(fil_beat)
		,.fil_chunk_wr_valid_i(fil_wr_valid)
		,.fil_chunk_wr_count_i(fil_wr_count)
		,.fil_chunk_wr_sel_i(fil_wr_sel)
		,.fil_chunk_rd_sel_i(fil_rd_sel)
		,.fil_chunk_cu_wr_sel_i(fil_cu_mask)
		,.run_valid_i(run_valid)
		,.total_chunk_start_i(chunk_start)
		,.rd_fil_sparsemap_last_i(seg_last)
		,.acc_buf_sel_i(acc_sel)
		,.total_chunk_end_o(chunk_end)
		,.com_unit_out_buf_sel_i(out_sel)
		,.out_buf_dat_o(out_buf)
	);

	bind compute_cluster compute_cluster_chk u_chk (
		 .clk_i(clk_i)
		,.rst_i(rst_i)
		,.start_i(total_chunk_start_i)
		,.run_valid_i(run_valid_i)
		,.chunk_end_i(total_chunk_end_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic stop_on_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic signed [7:0] rand_byte(input int density);
		logic signed [7:0] v;
		v = 8'sd0;
		if (($unsigned($random(seed)) % 100) < density) begin
			v = 8'($random(seed));
			if (v == 8'sd0) begin
				v = 8'sd1;
			end
		end
		return v;
	endfunction

	// Nonzeros go to the low bytes in position order
	function automatic chunk_beat_t pack_beat(input logic [BUS-1:0][7:0] vals);
		chunk_beat_t beat;
		int n;
		beat = '0;
		n = 0;
		for (int i = 0; i < BUS; i++) begin
			if (vals[i] != 8'd0) begin
				beat.sparsemap[i] = 1'b1;
				beat.data[n] = vals[i];
				n++;
			end
		end
		return beat;
	endfunction

	task automatic fill_ifm(input int bank, input int density);
		for (int p = 0; p < CHUNK; p++) begin
			ifm_mem[bank][p] = rand_byte(density);
		end
	endtask

	task automatic fill_fil(input int unit, input int bank, input int density);
		for (int p = 0; p < CHUNK; p++) begin
			fil_mem[unit][bank][p] = rand_byte(density);
		end
	endtask

	task automatic add_expected(input int ib, input int fb, input int last, input int a);
		for (int u = 0; u < CU_NUM; u++) begin
			for (int p = 0; p < (last + 1) * BUS; p++) begin
				exp_acc[u][a] += int'(ifm_mem[ib][p]) * int'(fil_mem[u][fb][p]);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Bus drivers and checks
	////////////////////////////////////////////////////////////////////////////

	task automatic write_ifm(input int bank);
		logic [BUS-1:0][7:0] vals;
		for (int b = 0; b < SEG_NUM; b++) begin
			for (int k = 0; k < BUS; k++) begin
				vals[k] = ifm_mem[bank][b * BUS + k];
			end
			@(negedge clk);
			ifm_beat = pack_beat(vals);
			ifm_wr_count = SEG_W'(b);
			ifm_wr_sel = bank[0];
			ifm_wr_valid = 1'b1;
		end
		@(negedge clk);
		ifm_wr_valid = 1'b0;
	endtask

	// Filter of unit src goes to every unit in the mask
	task automatic write_fil(input int src, input int bank, input logic [CU_NUM-1:0] mask);
		logic [BUS-1:0][7:0] vals;
		for (int u = 0; u < CU_NUM; u++) begin
			for (int p = 0; p < CHUNK; p++) begin
				if (mask[u]) begin
					fil_mem[u][bank][p] = fil_mem[src][bank][p];
				end
			end
		end
		for (int b = 0; b < SEG_NUM; b++) begin
			for (int k = 0; k < BUS; k++) begin
				vals[k] = fil_mem[src][bank][b * BUS + k];
			end
			@(negedge clk);
			fil_beat = pack_beat(vals);
			fil_wr_count = SEG_W'(b);
			fil_wr_sel = bank[0];
			fil_cu_mask = mask;
			fil_wr_valid = 1'b1;
		end
		@(negedge clk);
		fil_wr_valid = 1'b0;
	endtask

	task automatic write_all_units(input int bank, input int ifm_density, input int fil_density);
		fill_ifm(bank, ifm_density);
		write_ifm(bank);
		for (int u = 0; u < CU_NUM; u++) begin
			fill_fil(u, bank, fil_density);
			write_fil(u, bank, CU_NUM'(1 << u));
		end
	endtask

	task automatic clear_accs();
		@(negedge clk);
		run_valid = 1'b1;
		@(negedge clk);
		run_valid = 1'b0;
		for (int u = 0; u < CU_NUM; u++) begin
			for (int a = 0; a < OUT_NUM; a++) begin
				exp_acc[u][a] = 0;
			end
		end
	endtask

	task automatic start_chunk(input int ib, input int fb, input int last, input int a);
		add_expected(ib, fb, last, a);
		@(negedge clk);
		ifm_rd_sel = ib[0];
		fil_rd_sel = fb[0];
		seg_last = SEG_W'(last);
		acc_sel = ACC_SEL_W'(a);
		chunk_start = 1'b1;
		@(negedge clk);
		chunk_start = 1'b0;
		// Limit and select only count with the start strobe
		seg_last = ~SEG_W'(last);
		acc_sel = ~ACC_SEL_W'(a);
	endtask

	task automatic wait_chunk_end();
		while (chunk_end !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic check_results(input string name);
		acc_t want;
		acc_t got;
		for (int u = 0; u < CU_NUM; u++) begin
			@(negedge clk);
			out_sel = CU_W'(u);
			#1;
			for (int a = 0; a < OUT_NUM; a++) begin
				want = acc_t'(exp_acc[u][a]);
				got = out_buf.acc[a];
				assert (got == want) else begin
					stop_on_error($sformatf("%s: unit %0d acc %0d is %0d, expected %0d",
						name, u, a, got, want));
				end
			end
		end
	endtask

	task automatic run_and_check(input int ib, input int fb, input int last, input int a,
		input string name);
		start_chunk(ib, fb, last, a);
		wait_chunk_end();
		check_results(name);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		assert (chunk_end == 1'b0) else begin
			stop_on_error("total_chunk_end_o is high after reset");
		end
		check_results("reset");
	endtask

	task automatic test_dense();
		clear_accs();
		write_all_units(0, 100, 100);
		run_and_check(0, 0, 1, 0, "dense");
	endtask

	task automatic test_sparse();
		for (int r = 0; r < 4; r++) begin
			write_all_units(0, 40, 40);
			// Last round shares one filter over every unit
			if (r == 3) begin
				fill_fil(0, 0, 40);
				write_fil(0, 0, '1);
			end
			run_and_check(0, 0, 1, r % 2, "sparse");
		end
		// IFM on even positions and filters on odd ones
		for (int p = 0; p < CHUNK; p++) begin
			ifm_mem[0][p] = (p % 2 == 0) ? rand_byte(100) : 8'sd0;
			fil_mem[0][0][p] = (p % 2 == 1) ? rand_byte(100) : 8'sd0;
		end
		write_ifm(0);
		write_fil(0, 0, '1);
		run_and_check(0, 0, 1, 0, "no match");
	endtask

	task automatic test_double_buffer();
		clear_accs();
		write_all_units(0, 60, 60);
		fill_ifm(1, 60);
		for (int u = 0; u < CU_NUM; u++) begin
			fill_fil(u, 1, 60);
		end
		start_chunk(0, 0, 1, 0);
		write_ifm(1);
		for (int u = 0; u < CU_NUM; u++) begin
			write_fil(u, 1, CU_NUM'(1 << u));
		end
		wait_chunk_end();
		check_results("bank 0 during bank 1 write");
		run_and_check(1, 1, 1, 0, "bank 1");
	endtask

	task automatic test_acc_select();
		clear_accs();
		write_all_units(0, 50, 50);
		run_and_check(0, 0, 1, 0, "acc 0");
		run_and_check(0, 0, 1, 1, "acc 1 first");
		run_and_check(0, 0, 1, 1, "acc 1 second");
		clear_accs();
		check_results("after clear");
	endtask

	task automatic test_seg_limit();
		clear_accs();
		write_all_units(0, 100, 100);
		run_and_check(0, 0, 0, 0, "segment 0 only");
	endtask

	initial begin
		seed = 32'h6d1c;
		clk = 1'b0;
		rst = 1'b1;
		ifm_beat = '0;
		ifm_wr_valid = 1'b0;
		ifm_wr_count = '0;
		ifm_wr_sel = 1'b0;
		ifm_rd_sel = 1'b0;
		fil_beat = '0;
		fil_wr_valid = 1'b0;
		fil_wr_count = '0;
		fil_wr_sel = 1'b0;
		fil_rd_sel = 1'b0;
		fil_cu_mask = '0;
		run_valid = 1'b0;
		chunk_start = 1'b0;
		seg_last = '0;
		acc_sel = '0;
		out_sel = '0;
		for (int p = 0; p < CHUNK; p++) begin
			for (int b = 0; b < 2; b++) begin
				ifm_mem[b][p] = 8'sd0;
				for (int u = 0; u < CU_NUM; u++) begin
					fil_mem[u][b][p] = 8'sd0;
				end
			end
		end
		for (int u = 0; u < CU_NUM; u++) begin
			for (int a = 0; a < OUT_NUM; a++) begin
				exp_acc[u][a] = 0;
			end
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		test_reset_state();
		test_dense();
		test_sparse();
		test_double_buffer();
		test_acc_select();
		test_seg_limit();

		@(negedge clk);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: verif/compute_cluster_chk.sv
`timescale 1ns/10ps

module compute_cluster_chk (
	 input  logic clk_i
	,input  logic rst_i
	,input  logic start_i
	,input  logic run_valid_i
	,input  logic chunk_end_i
);

	logic started_r;
	logic busy;

	// Set by a start, dropped once the cluster reports chunk end
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			started_r <= 1'b0;
		end else if (start_i) begin
			started_r <= 1'b1;
		end else if (chunk_end_i) begin
			started_r <= 1'b0;
		end
	end

	assign busy = started_r && !chunk_end_i;

	////////////////////////////////////////////////////////////////////////////
	// Control timing
	////////////////////////////////////////////////////////////////////////////

	end_low_after_start: assert property (@(posedge clk_i) disable iff (rst_i)
		start_i |=> !chunk_end_i)
		else $error("chunk end still high the cycle after a start strobe");

	no_start_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		!(start_i && busy))
		else $error("start strobe arrived before the running chunk ended");

	no_clear_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		!(run_valid_i && busy))
		else $error("accumulator clear arrived while a chunk was running");

endmodule

// File: hdl/compute_cluster.sv
`timescale 1ns/10ps
`include "sparse_cnn_params.svh"

module compute_cluster import sparse_cnn_pkg::*; (
	 input  logic clk_i
	,input  logic rst_i

	,input  chunk_beat_t ifm_beat_i
	,input  logic ifm_chunk_wr_valid_i
	,input  logic [`SEG_IDX_W-1:0] ifm_chunk_wr_count_i
	,input  logic ifm_chunk_wr_sel_i
	,input  logic ifm_chunk_rd_sel_i

	,input  chunk_beat_t fil_beat_i
	,input  logic fil_chunk_wr_valid_i
	,input  logic [`SEG_IDX_W-1:0] fil_chunk_wr_count_i
	,input  logic fil_chunk_wr_sel_i
	,input  logic fil_chunk_rd_sel_i
	,input  logic [`COMPUTE_UNIT_NUM-1:0] fil_chunk_cu_wr_sel_i

	,input  logic run_valid_i
	,input  logic total_chunk_start_i
	,input  logic [`SEG_IDX_W-1:0] rd_fil_sparsemap_last_i
	,input  logic [`ACC_SEL_W-1:0] acc_buf_sel_i
	,output logic total_chunk_end_o

	,input  logic [`CU_IDX_W-1:0] com_unit_out_buf_sel_i
	,output out_buf_t out_buf_dat_o
);

	chunk_wr_t ifm_wr_w;
	chunk_wr_t fil_wr_w;
	logic [`COMPUTE_UNIT_NUM-1:0] fil_wr_valid_w;
	logic [`COMPUTE_UNIT_NUM-1:0] chunk_end_w;
	out_buf_t [`COMPUTE_UNIT_NUM-1:0] out_buf_w;

	assign ifm_wr_w = '{
		beat: ifm_beat_i,
		count: ifm_chunk_wr_count_i,
		sel: ifm_chunk_wr_sel_i
	};

	assign fil_wr_w = '{
		beat: fil_beat_i,
		count: fil_chunk_wr_count_i,
		sel: fil_chunk_wr_sel_i
	};

	// Filter beats only reach units named in the mask
	assign fil_wr_valid_w = fil_chunk_cu_wr_sel_i & {`COMPUTE_UNIT_NUM{fil_chunk_wr_valid_i}};

	for (genvar i = 0; i < `COMPUTE_UNIT_NUM; i++) begin : gen_com_unit
		compute_unit u_compute_unit (
			 .clk_i
			,.rst_i
			,.ifm_wr_i(ifm_wr_w)
			,.fil_wr_i(fil_wr_w)
			,.ifm_wr_valid_i(ifm_chunk_wr_valid_i)
			,.fil_wr_valid_i(fil_wr_valid_w[i])
			,.ifm_rd_sel_i(ifm_chunk_rd_sel_i)
			,.fil_rd_sel_i(fil_chunk_rd_sel_i)
			,.sub_chunk_start_i(total_chunk_start_i)
			,.rd_fil_sparsemap_last_i
			,.acc_buf_sel_i
			,.clear_i(run_valid_i)
			,.sub_chunk_end_o(chunk_end_w[i])
			,.out_buf_dat_o(out_buf_w[i])
		);
	end

	assign total_chunk_end_o = &chunk_end_w;
	assign out_buf_dat_o = out_buf_w[com_unit_out_buf_sel_i];

endmodule

// File: hdl/compute_unit.sv
`timescale 1ns/10ps
`include "sparse_cnn_params.svh"

module compute_unit import sparse_cnn_pkg::*; (
	 input  logic clk_i
	,input  logic rst_i

	,input  chunk_wr_t ifm_wr_i
	,input  chunk_wr_t fil_wr_i
	,input  logic ifm_wr_valid_i
	,input  logic fil_wr_valid_i
	,input  logic ifm_rd_sel_i
	,input  logic fil_rd_sel_i

	,input  logic sub_chunk_start_i
	,input  logic [`SEG_IDX_W-1:0] rd_fil_sparsemap_last_i
	,input  logic [`ACC_SEL_W-1:0] acc_buf_sel_i
	,input  logic clear_i

	,output logic sub_chunk_end_o
	,output out_buf_t out_buf_dat_o
);

	logic [`SEG_IDX_W-1:0] seg_w;
	logic [`BUS_SIZE-1:0] ifm_sm_w;
	logic [`BUS_SIZE-1:0] fil_sm_w;
	logic [`CHUNK_ADDR_W-1:0] ifm_addr_w;
	logic [`CHUNK_ADDR_W-1:0] fil_addr_w;
	logic signed [7:0] ifm_data_w;
	logic signed [7:0] fil_data_w;
	logic done_w;
	logic chunk_end_r;

	sparse_chunk_buf u_ifm_buf (
		 .clk_i
		,.rst_i
		,.wr_i(ifm_wr_i)
		,.wr_valid_i(ifm_wr_valid_i)
		,.rd_sel_i(ifm_rd_sel_i)
		,.rd_seg_i(seg_w)
		,.rd_sparsemap_o(ifm_sm_w)
		,.rd_addr_i(ifm_addr_w)
		,.rd_data_o(ifm_data_w)
	);

	sparse_chunk_buf u_fil_buf (
		 .clk_i
		,.rst_i
		,.wr_i(fil_wr_i)
		,.wr_valid_i(fil_wr_valid_i)
		,.rd_sel_i(fil_rd_sel_i)
		,.rd_seg_i(seg_w)
		,.rd_sparsemap_o(fil_sm_w)
		,.rd_addr_i(fil_addr_w)
		,.rd_data_o(fil_data_w)
	);

	sparse_match_engine u_engine (
		 .clk_i
		,.rst_i
		,.start_i(sub_chunk_start_i)
		,.seg_last_i(rd_fil_sparsemap_last_i)
		,.acc_sel_i(acc_buf_sel_i)
		,.clear_i
		,.seg_o(seg_w)
		,.ifm_sparsemap_i(ifm_sm_w)
		,.fil_sparsemap_i(fil_sm_w)
		,.ifm_addr_o(ifm_addr_w)
		,.fil_addr_o(fil_addr_w)
		,.ifm_data_i(ifm_data_w)
		,.fil_data_i(fil_data_w)
		,.done_o(done_w)
		,.acc_o(out_buf_dat_o)
	);

	// Held high until the next start
	always_ff @(posedge clk_i) begin
		if (rst_i || sub_chunk_start_i) begin
			chunk_end_r <= 1'b0;
		end else if (done_w) begin
			chunk_end_r <= 1'b1;
		end
	end

	assign sub_chunk_end_o = chunk_end_r;

endmodule

// File: hdl/sparse_match_engine.sv
`timescale 1ns/10ps
`include "sparse_cnn_params.svh"

module sparse_match_engine import sparse_cnn_pkg::*; (
	 input  logic clk_i
	,input  logic rst_i

	,input  logic start_i
	,input  logic [`SEG_IDX_W-1:0] seg_last_i
	,input  logic [`ACC_SEL_W-1:0] acc_sel_i
	,input  logic clear_i

	,output logic [`SEG_IDX_W-1:0] seg_o
	,input  logic [`BUS_SIZE-1:0] ifm_sparsemap_i
	,input  logic [`BUS_SIZE-1:0] fil_sparsemap_i

	,output logic [`CHUNK_ADDR_W-1:0] ifm_addr_o
	,output logic [`CHUNK_ADDR_W-1:0] fil_addr_o
	,input  logic signed [7:0] ifm_data_i
	,input  logic signed [7:0] fil_data_i

	,output logic done_o
	,output out_buf_t acc_o
);

	localparam int POS_W = `POS_IDX_W;
	localparam int ADDR_W = `CHUNK_ADDR_W;

	logic active_r;
	logic first_r;
	logic [`SEG_IDX_W-1:0] seg_r;
	logic [`SEG_IDX_W-1:0] seg_last_r;
	logic [`SEG_IDX_W-1:0] seg_nxt;
	logic [`ACC_SEL_W-1:0] acc_sel_r;
	logic [`BUS_SIZE-1:0] remain_r;
	logic [`BUS_SIZE-1:0] mask_cur;
	logic [`BUS_SIZE-1:0] mask_rest;
	logic [POS_W-1:0] pos;
	logic hit;
	logic seg_done;
	logic chunk_done;
	logic [ADDR_W-1:0] seg_base;
	logic mac2_r;
	logic last2_r;
	logic mac3_r;
	logic last3_r;
	logic signed [7:0] ifm_op3_r;
	logic signed [7:0] fil_op3_r;
	logic signed [15:0] prod;
	out_buf_t acc_r;

	// Prefix sum of the map bits below a position
	function automatic logic [ADDR_W-1:0] count_below(
		input logic [`BUS_SIZE-1:0] sm,
		input logic [POS_W-1:0] p
	);
		logic [ADDR_W-1:0] cnt;
		cnt = '0;
		for (int i = 0; i < `BUS_SIZE; i++) begin
			if (i < int'(p) && sm[i]) begin
				cnt = cnt + ADDR_W'(1);
			end
		end
		return cnt;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stage 1: match select and address generation
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		mask_cur = first_r ? (ifm_sparsemap_i & fil_sparsemap_i) : remain_r;
		hit = |mask_cur;
		// Lowest set bit wins
		pos = '0;
		for (int i = `BUS_SIZE - 1; i >= 0; i--) begin
			if (mask_cur[i]) begin
				pos = POS_W'(i);
			end
		end
		mask_rest = mask_cur & (mask_cur - 1'b1);
		seg_done = (mask_rest == '0);
		chunk_done = active_r && seg_done && (seg_r == seg_last_r);
	end

	// Map of the next segment is fetched a cycle ahead
	always_comb begin
		seg_nxt = seg_r;
		if (!active_r && start_i) begin
			seg_nxt = '0;
		end else if (active_r && seg_done && (seg_r != seg_last_r)) begin
			seg_nxt = seg_r + 1'b1;
		end
	end

	assign seg_o = seg_nxt;
	assign seg_base = ADDR_W'(int'(seg_r) * `BUS_SIZE);
	assign ifm_addr_o = seg_base + count_below(ifm_sparsemap_i, pos);
	assign fil_addr_o = seg_base + count_below(fil_sparsemap_i, pos);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			active_r <= 1'b0;
			first_r <= 1'b0;
			seg_r <= '0;
			seg_last_r <= '0;
			acc_sel_r <= '0;
		end else begin
			seg_r <= seg_nxt;
			if (!active_r) begin
				if (start_i) begin
					active_r <= 1'b1;
					first_r <= 1'b1;
					seg_last_r <= seg_last_i;
					acc_sel_r <= acc_sel_i;
				end
			end else begin
				first_r <= seg_done;
				if (chunk_done) begin
					active_r <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		remain_r <= mask_rest;
	end

	////////////////////////////////////////////////////////////////////////////
	// Stages 2 and 3: operand read, multiply and accumulate
	////////////////////////////////////////////////////////////////////////////

	// Last token also flows for a chunk without matches
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mac2_r <= 1'b0;
			last2_r <= 1'b0;
			mac3_r <= 1'b0;
			last3_r <= 1'b0;
		end else begin
			mac2_r <= active_r && hit;
			last2_r <= chunk_done;
			mac3_r <= mac2_r;
			last3_r <= last2_r;
		end
	end

	always_ff @(posedge clk_i) begin
		ifm_op3_r <= ifm_data_i;
		fil_op3_r <= fil_data_i;
	end

	assign prod = ifm_op3_r * fil_op3_r;

	always_ff @(posedge clk_i) begin
		if (rst_i || clear_i) begin
			acc_r <= '0;
		end else if (mac3_r) begin
			acc_r.acc[acc_sel_r] <= acc_r.acc[acc_sel_r] + acc_t'(prod);
		end
	end

	assign done_o = last3_r;
	assign acc_o = acc_r;

endmodule

// File: hdl/sparse_chunk_buf.sv
`timescale 1ns/10ps
`include "sparse_cnn_params.svh"

module sparse_chunk_buf import sparse_cnn_pkg::*; (
	 input  logic clk_i
	,input  logic rst_i

	,input  chunk_wr_t wr_i
	,input  logic wr_valid_i

	,input  logic rd_sel_i
	,input  logic [`SEG_IDX_W-1:0] rd_seg_i
	,output logic [`BUS_SIZE-1:0] rd_sparsemap_o

	,input  logic [`CHUNK_ADDR_W-1:0] rd_addr_i
	,output logic signed [7:0] rd_data_o
);

	logic [1:0][`WR_DAT_CYC_NUM-1:0][`BUS_SIZE-1:0] sparsemap_r;
	logic [7:0] data_r [2][`CHUNK_SIZE];

	////////////////////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////////////////////

	// Cleared maps make an unwritten bank produce no matches
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sparsemap_r <= '0;
		end else if (wr_valid_i) begin
			sparsemap_r[wr_i.sel][wr_i.count] <= wr_i.beat.sparsemap;
		end
	end

	// Beat b fills bytes 8b to 8b+7
	always_ff @(posedge clk_i) begin
		int base;
		base = int'(wr_i.count) * `BUS_SIZE;
		if (wr_valid_i) begin
			for (int k = 0; k < `BUS_SIZE; k++) begin
				data_r[wr_i.sel][base + k] <= wr_i.beat.data[k];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side, one cycle from address to data
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rd_sparsemap_o <= '0;
		end else begin
			rd_sparsemap_o <= sparsemap_r[rd_sel_i][rd_seg_i];
		end
	end

	always_ff @(posedge clk_i) begin
		rd_data_o <= data_r[rd_sel_i][rd_addr_i];
	end

endmodule

// File: hdl/sparse_cnn_pkg.sv
`include "sparse_cnn_params.svh"

package sparse_cnn_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Chunk write path
	////////////////////////////////////////////////////////////////////////////

	// One compressed beat, nonzeros packed toward byte 0
	typedef struct packed {
		logic [`BUS_SIZE-1:0] sparsemap;
		logic [`BUS_SIZE-1:0][7:0] data;
	} chunk_beat_t;

	// Beat with its position in the chunk and target bank
	typedef struct packed {
		chunk_beat_t beat;
		logic [`SEG_IDX_W-1:0] count;
		logic sel;
	} chunk_wr_t;

	////////////////////////////////////////////////////////////////////////////
	// Accumulators
	////////////////////////////////////////////////////////////////////////////

	typedef logic signed [`ACC_WIDTH-1:0] acc_t;

	// All accumulators of one unit
	typedef struct packed {
		acc_t [`OUTPUT_BUF_NUM-1:0] acc;
	} out_buf_t;

endpackage

// File: hdl/sparse_cnn_params.svh
`ifndef SPARSE_CNN_PARAMS_SVH
`define SPARSE_CNN_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus and chunk geometry
////////////////////////////////////////////////////////////////////////////

// Positions per write beat and per read segment
`define BUS_SIZE 8

// Beats per chunk, same as segments per chunk
`define WR_DAT_CYC_NUM 2

`define CHUNK_SIZE 16

////////////////////////////////////////////////////////////////////////////
// Cluster and accumulator sizes
////////////////////////////////////////////////////////////////////////////

`define COMPUTE_UNIT_NUM 4
`define OUTPUT_BUF_NUM 2
`define ACC_WIDTH 24

// Derived index widths
`define SEG_IDX_W ($clog2(`WR_DAT_CYC_NUM))
`define POS_IDX_W ($clog2(`BUS_SIZE))
`define CHUNK_ADDR_W ($clog2(`CHUNK_SIZE))
`define CU_IDX_W ($clog2(`COMPUTE_UNIT_NUM))
`define ACC_SEL_W ($clog2(`OUTPUT_BUF_NUM))

`endif
